// ==== hw/net_cfg_pkg.sv ====
/*
  network configuration constants for the udp transmit path
  station identity, udp source port, ipv4 header fields and
  ethernet framing values (preamble, minimum size, gap, crc-32)
*/
package net_cfg_pkg;

  // ------------------------------------------------------------------------
  // station identity
  // ------------------------------------------------------------------------
  // bit 1 is overwritten with the inverted macbit pin
  localparam logic [47:0] local_mac_base = 48'h02_1a_3c_00_40_5e;
  // 192.168.1.50
  localparam logic [31:0] local_ip       = 32'hc0_a8_01_32;
  localparam logic [15:0] local_udp_port = 16'd1024;

  // ------------------------------------------------------------------------
  // ipv4 / udp header fields
  // ------------------------------------------------------------------------
  localparam logic [7:0]  ip_ttl         = 8'h80;
  // don't fragment, offset zero
  localparam logic [15:0] ip_flags_frag  = 16'h4000;
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [7:0]  ip_proto_udp   = 8'h11;
  localparam int          ip_header_len  = 20;
  localparam int          udp_header_len = 8;

  // ------------------------------------------------------------------------
  // ethernet framing
  // ------------------------------------------------------------------------
  localparam logic [7:0]  preamble_byte  = 8'h55;
  localparam logic [7:0]  sfd_byte       = 8'hd5;
  localparam int          preamble_len   = 7;
  // smallest ethernet payload, short ip packets are zero padded
  localparam int          min_ip_bytes   = 46;
  localparam int          ifg_bytes      = 12;
  // reflected form, shifted out lsb first
  localparam logic [31:0] crc_poly         = 32'hedb8_8320;
  localparam logic [31:0] crc_residue_init = 32'hffff_ffff;

endpackage

// ==== hw/frame_pkg.sv ====
/*
  types shared along the udp transmit chain
  destination and job records, the byte beat from the ip/udp
  builder to the mac framer, and the state encodings of both
*/
package frame_pkg;

  // where a frame goes
  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } udp_dest_t;

  // one accepted send request
  typedef struct packed {
    udp_dest_t   dest;
    // udp payload bytes, 1 to 1472
    logic [15:0] payload_len;
    logic [15:0] ip_id;
  } tx_job_t;

  // current ip byte offered to the framer
  typedef struct packed {
    logic [7:0] data;
    // final payload byte of the packet
    logic       last;
  } ip_beat_t;

  // ------------------------------------------------------------------------
  // state encodings
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    bld_idle,
    bld_ip_hdr,
    bld_udp_hdr,
    bld_payload
  } builder_phase_e;

  typedef enum logic [2:0] {
    frm_idle,
    frm_preamble,
    frm_sfd,
    frm_mac_hdr,
    frm_body,
    frm_pad,
    frm_fcs,
    frm_gap
  } framer_state_e;

endpackage

// ==== hw/udp_tx_frontend.sv ====
/*
  udp send request front end
  takes one held request at a time, latches destination and length
  into a transmit job stamped with a running ip id, and keeps the
  path busy until the framer reports the end of the gap
*/
`timescale 1ns/1ps

module udp_tx_frontend (
  input  logic                 tx_clock,
  input  logic                 rst_n,
  input  logic                 udp_tx_request,
  input  logic [15:0]          udp_tx_length,
  input  frame_pkg::udp_dest_t udp_dest,
  input  logic                 frame_done,
  output logic                 udp_tx_enable,
  output logic                 udp_tx_active,
  output frame_pkg::tx_job_t   job,
  output logic                 job_start
);

  logic        accept;
  logic        start_q;
  logic [15:0] ip_id_cnt;

  // a request held while busy just waits here
  assign accept = udp_tx_request && !udp_tx_active;

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      start_q       <= 1'b0;
      udp_tx_active <= 1'b0;
      ip_id_cnt     <= 16'd0;
    end else begin
      start_q <= accept;
      if (frame_done) begin
        udp_tx_active <= 1'b0;
      end else if (accept) begin
        udp_tx_active <= 1'b1;
      end
      // next frame gets the next id
      if (accept) begin
        ip_id_cnt <= ip_id_cnt + 16'd1;
      end
    end
  end

  // job is stable from the start pulse until the next acceptance
  always_ff @(posedge tx_clock) begin
    if (accept) begin
      job.dest        <= udp_dest;
      job.payload_len <= udp_tx_length;
      job.ip_id       <= ip_id_cnt;
    end
  end

  // enable to the user and start to the chain are the same pulse
  assign udp_tx_enable = start_q;
  assign job_start     = start_q;

  // no second job until the framer has closed the gap of this one
  ap_one_job: assert property (@(posedge tx_clock) disable iff (!rst_n)
    job_start |=> (!job_start throughout frame_done[->1]))
    else $error("job_start while a frame is still in flight");

endmodule

// ==== hw/ip_udp_builder.sv ====
/*
  ipv4 and udp header builder
  emits the 20 byte ip header (with header checksum) and the 8 byte
  udp header, msb first, then pulls payload bytes from the user one
  strobe at a time; the framer advances it with ip_next
*/
`timescale 1ns/1ps

module ip_udp_builder (
  input  logic                tx_clock,
  input  logic                rst_n,
  input  frame_pkg::tx_job_t  job,
  input  logic                job_start,
  input  logic                ip_next,
  input  logic [7:0]          udp_tx_data,
  output frame_pkg::ip_beat_t ip_beat,
  output logic                udp_data_strobe
);

  frame_pkg::builder_phase_e phase;
  logic [15:0]      pos;
  logic [15:0]      pos_nxt;
  logic [15:0]      hdr_len;
  logic [15:0]      total_len;
  logic [15:0]      udp_len;
  logic [15:0]      last_pos;
  logic [15:0]      ip_cksum;
  logic [31:0]      sum;
  logic [16:0]      fold;
  logic [27:0][7:0] hdr;
  logic             sum_pending;
  logic             advance;

  assign hdr_len   = 16'(net_cfg_pkg::ip_header_len + net_cfg_pkg::udp_header_len);
  assign total_len = hdr_len + job.payload_len;
  assign udp_len   = 16'(net_cfg_pkg::udp_header_len) + job.payload_len;
  // pos runs over header and payload, 0 is the 0x45 byte
  assign last_pos  = total_len - 16'd1;

  // ------------------------------------------------------------------------
  // header image, byte 0 in hdr[27]
  // ------------------------------------------------------------------------
  assign hdr = {8'h45, 8'h00, total_len, job.ip_id, net_cfg_pkg::ip_flags_frag,
                net_cfg_pkg::ip_ttl, net_cfg_pkg::ip_proto_udp, ip_cksum,
                net_cfg_pkg::local_ip, job.dest.ip,
                net_cfg_pkg::local_udp_port, job.dest.port, udp_len, 16'h0000};

  // ones' complement sum of the ten header words, checksum word as zero
  assign sum = 32'(16'h4500) + 32'(total_len) + 32'(job.ip_id)
             + 32'(net_cfg_pkg::ip_flags_frag)
             + 32'({net_cfg_pkg::ip_ttl, net_cfg_pkg::ip_proto_udp})
             + 32'(net_cfg_pkg::local_ip[31:16]) + 32'(net_cfg_pkg::local_ip[15:0])
             + 32'(job.dest.ip[31:16]) + 32'(job.dest.ip[15:0]);
  // end-around carry, second fold cannot carry again
  assign fold = {1'b0, sum[15:0]} + {1'b0, sum[31:16]};

  assign advance = ip_next && (phase != frame_pkg::bld_idle);
  assign pos_nxt = pos + 16'd1;
  // user byte is taken in the same cycle the framer asks for it
  assign udp_data_strobe = advance && !ip_beat.last && (pos_nxt >= hdr_len);

  // ------------------------------------------------------------------------
  // phase and position
  // ------------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      phase       <= frame_pkg::bld_idle;
      pos         <= 16'd0;
      sum_pending <= 1'b0;
    end else begin
      sum_pending <= job_start;
      if (job_start) begin
        phase <= frame_pkg::bld_ip_hdr;
        pos   <= 16'd0;
      end else if (advance) begin
        pos <= pos_nxt;
        if (ip_beat.last) begin
          phase <= frame_pkg::bld_idle;
        end else if (pos_nxt == 16'(net_cfg_pkg::ip_header_len)) begin
          phase <= frame_pkg::bld_udp_hdr;
        end else if (pos_nxt == hdr_len) begin
          phase <= frame_pkg::bld_payload;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // checksum and current byte
  // ------------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    // job settled one cycle before, byte 10 is needed much later
    if (sum_pending) begin
      ip_cksum <= ~(fold[15:0] + {15'd0, fold[16]});
    end
    if (job_start) begin
      ip_beat.data <= hdr[27];
      ip_beat.last <= 1'b0;
    end else if (advance) begin
      if (pos_nxt < hdr_len) begin
        ip_beat.data <= hdr[5'd27 - pos_nxt[4:0]];
      end else begin
        ip_beat.data <= udp_tx_data;
      end
      ip_beat.last <= (pos_nxt == last_pos);
    end
  end

  // a sampled user byte always lands in the payload phase
  ap_strobe_payload: assert property (@(posedge tx_clock) disable iff (!rst_n)
    udp_data_strobe |=> (phase == frame_pkg::bld_payload))
    else $error("udp_data_strobe outside the payload phase");

endmodule

// ==== hw/mac_framer.sv ====
/*
  ethernet mac framer
  wraps the ip byte stream in preamble, sfd and mac header, pads the
  body to the minimum size, appends the crc-32 fcs and holds the
  inter-frame gap; one byte per byte_next from the nibble stage
*/
`timescale 1ns/1ps

module mac_framer (
  input  logic                tx_clock,
  input  logic                rst_n,
  input  logic                job_start,
  input  frame_pkg::tx_job_t  job,
  input  frame_pkg::ip_beat_t ip_beat,
  input  logic                byte_next,
  input  logic                macbit,
  output logic                ip_next,
  output logic [7:0]          frame_byte,
  output logic                frame_valid,
  output logic                frame_done,
  output logic [47:0]         local_mac
);

  frame_pkg::framer_state_e state;
  // index of the next byte within the current section
  logic [10:0]      cnt;
  logic             body_last;
  logic             crc_en;
  logic             body_full;
  logic [31:0]      crc;
  logic [31:0]      crc_nxt;
  logic [13:0][7:0] mac_hdr;

  // one crc-32 byte step, lsb first
  function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      if (r[0] ^ d[i]) begin
        r = (r >> 1) ^ net_cfg_pkg::crc_poly;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  assign local_mac = {net_cfg_pkg::local_mac_base[47:2], ~macbit,
                      net_cfg_pkg::local_mac_base[0]};
  assign mac_hdr   = {job.dest.mac, local_mac, net_cfg_pkg::ethertype_ipv4};

  // fcs covers header, body and pad
  assign crc_en    = state inside {frame_pkg::frm_mac_hdr, frame_pkg::frm_body,
                                   frame_pkg::frm_pad};
  assign crc_nxt   = crc_update(crc, frame_byte);
  assign body_full = cnt >= 11'(net_cfg_pkg::min_ip_bytes);

  // builder advances whenever its current byte is loaded
  assign ip_next = byte_next &&
                   ((state == frame_pkg::frm_mac_hdr && cnt == 11'd14) ||
                    (state == frame_pkg::frm_body && !body_last));

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state       <= frame_pkg::frm_idle;
      cnt         <= 11'd0;
      frame_valid <= 1'b0;
      frame_done  <= 1'b0;
      frame_byte  <= 8'h00;
      crc         <= 32'd0;
      body_last   <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (byte_next && crc_en) begin
        crc <= crc_nxt;
      end
      case (state)
        frame_pkg::frm_idle: begin
          if (job_start) begin
            state       <= frame_pkg::frm_preamble;
            frame_valid <= 1'b1;
            frame_byte  <= net_cfg_pkg::preamble_byte;
            cnt         <= 11'd1;
            crc         <= net_cfg_pkg::crc_residue_init;
          end
        end
        frame_pkg::frm_preamble: begin
          if (byte_next) begin
            if (cnt == 11'(net_cfg_pkg::preamble_len)) begin
              state      <= frame_pkg::frm_sfd;
              frame_byte <= net_cfg_pkg::sfd_byte;
            end else begin
              frame_byte <= net_cfg_pkg::preamble_byte;
              cnt        <= cnt + 11'd1;
            end
          end
        end
        frame_pkg::frm_sfd: begin
          if (byte_next) begin
            state      <= frame_pkg::frm_mac_hdr;
            frame_byte <= mac_hdr[13];
            cnt        <= 11'd1;
          end
        end
        // dest mac, source mac, ethertype
        frame_pkg::frm_mac_hdr: begin
          if (byte_next) begin
            if (cnt == 11'd14) begin
              state      <= frame_pkg::frm_body;
              frame_byte <= ip_beat.data;
              body_last  <= ip_beat.last;
              cnt        <= 11'd1;
            end else begin
              frame_byte <= mac_hdr[4'd13 - cnt[3:0]];
              cnt        <= cnt + 11'd1;
            end
          end
        end
        // cnt counts body bytes loaded, pad included
        frame_pkg::frm_body, frame_pkg::frm_pad: begin
          if (byte_next) begin
            if (state == frame_pkg::frm_body && !body_last) begin
              frame_byte <= ip_beat.data;
              body_last  <= ip_beat.last;
              cnt        <= cnt + 11'd1;
            end else if (!body_full) begin
              state      <= frame_pkg::frm_pad;
              frame_byte <= 8'h00;
              cnt        <= cnt + 11'd1;
            end else begin
              // first fcs byte straight from the final crc step
              state      <= frame_pkg::frm_fcs;
              frame_byte <= ~crc_nxt[7:0];
              cnt        <= 11'd1;
            end
          end
        end
        frame_pkg::frm_fcs: begin
          if (byte_next) begin
            if (cnt == 11'd4) begin
              state       <= frame_pkg::frm_gap;
              frame_valid <= 1'b0;
              cnt         <= 11'd0;
            end else begin
              frame_byte <= ~crc[{cnt[1:0], 3'b000} +: 8];
              cnt        <= cnt + 11'd1;
            end
          end
        end
        // two clocks per gap byte
        frame_pkg::frm_gap: begin
          if (cnt == 11'(net_cfg_pkg::ifg_bytes * 2 - 1)) begin
            state      <= frame_pkg::frm_idle;
            frame_done <= 1'b1;
            cnt        <= 11'd0;
          end else begin
            cnt <= cnt + 11'd1;
          end
        end
        default: state <= frame_pkg::frm_idle;
      endcase
    end
  end

  // every byte pulled from the builder goes out as body
  ap_ip_next_body: assert property (@(posedge tx_clock) disable iff (!rst_n)
    ip_next |=> (state == frame_pkg::frm_body))
    else $error("ip_next outside the body of the frame");

endmodule

// ==== hw/nibble_tx.sv ====
/*
  100 mbit nibble transmitter
  sends each frame byte as two nibbles, low first, on PHY_TX with
  PHY_TX_EN and asks the framer for the next byte every two clocks
*/
`timescale 1ns/1ps

module nibble_tx (
  input  logic       tx_clock,
  input  logic       rst_n,
  input  logic [7:0] frame_byte,
  input  logic       frame_valid,
  output logic       byte_next,
  output logic [3:0] PHY_TX,
  output logic       PHY_TX_EN
);

  logic       hi_phase;
  // framer moves on right after the low nibble, keep the high one
  logic [3:0] hi_nib;

  assign byte_next = frame_valid && !hi_phase;

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      hi_phase  <= 1'b0;
      PHY_TX_EN <= 1'b0;
    end else begin
      hi_phase  <= byte_next;
      // high nibble still goes out after frame_valid drops
      PHY_TX_EN <= byte_next || hi_phase;
    end
  end

  always_ff @(posedge tx_clock) begin
    if (byte_next) begin
      PHY_TX <= frame_byte[3:0];
      hi_nib <= frame_byte[7:4];
    end else if (hi_phase) begin
      PHY_TX <= hi_nib;
    end else begin
      PHY_TX <= 4'h0;
    end
  end

  // both nibbles of a byte leave with enable high
  ap_en_pair: assert property (@(posedge tx_clock) disable iff (!rst_n)
    byte_next |=> PHY_TX_EN [*2])
    else $error("PHY_TX_EN dropped inside a byte");

endmodule

// ==== hw/network_tx.sv ====
/*
  udp transmit path, top level
  request front end, ip/udp header builder, mac framer and
  nibble transmitter in the tx_clock domain
*/
`timescale 1ns/1ps

module network_tx (
  input  logic                 tx_clock,
  input  logic                 rst_n,
  input  logic                 udp_tx_request,
  input  logic [15:0]          udp_tx_length,
  input  frame_pkg::udp_dest_t udp_dest,
  input  logic [7:0]           udp_tx_data,
  input  logic                 macbit,
  output logic                 udp_tx_enable,
  output logic                 udp_tx_active,
  output logic                 udp_data_strobe,
  output logic [47:0]          local_mac,
  output logic [3:0]           PHY_TX,
  output logic                 PHY_TX_EN
);

  frame_pkg::tx_job_t  job;
  frame_pkg::ip_beat_t ip_beat;
  logic                job_start;
  logic                ip_next;
  logic [7:0]          frame_byte;
  logic                frame_valid;
  logic                frame_done;
  logic                byte_next;

  // ------------------------------------------------------------------------
  // request in, job out
  // ------------------------------------------------------------------------
  udp_tx_frontend u_frontend (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .udp_tx_request (udp_tx_request),
    .udp_tx_length  (udp_tx_length),
    .udp_dest       (udp_dest),
    .frame_done     (frame_done),
    .udp_tx_enable  (udp_tx_enable),
    .udp_tx_active  (udp_tx_active),
    .job            (job),
    .job_start      (job_start)
  );

  // headers and payload bytes
  ip_udp_builder u_builder (
    .tx_clock        (tx_clock),
    .rst_n           (rst_n),
    .job             (job),
    .job_start       (job_start),
    .ip_next         (ip_next),
    .udp_tx_data     (udp_tx_data),
    .ip_beat         (ip_beat),
    .udp_data_strobe (udp_data_strobe)
  );

  // ------------------------------------------------------------------------
  // ethernet frame and phy side
  // ------------------------------------------------------------------------
  mac_framer u_framer (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .job_start   (job_start),
    .job         (job),
    .ip_beat     (ip_beat),
    .byte_next   (byte_next),
    .macbit      (macbit),
    .ip_next     (ip_next),
    .frame_byte  (frame_byte),
    .frame_valid (frame_valid),
    .frame_done  (frame_done),
    .local_mac   (local_mac)
  );

  nibble_tx u_nibble (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .frame_byte  (frame_byte),
    .frame_valid (frame_valid),
    .byte_next   (byte_next),
    .PHY_TX      (PHY_TX),
    .PHY_TX_EN   (PHY_TX_EN)
  );

endmodule

// ==== verification/network_tx_tb.sv ====
/*
  testbench for the udp transmit path
  drives a table of send requests, feeds payload bytes on each strobe,
  rebuilds bytes from the phy nibbles and compares every frame with a
  reference model of headers, ip checksum, padding and crc-32
*/
`timescale 1ns/1ps

module network_tx_tb;

  localparam int          n_cases        = 5;
  localparam int          max_payload    = 1472;
  localparam int          min_gap_cycles = 24;
  localparam logic [31:0] lcg_seed       = 32'h3fa0_7d57;

  typedef struct packed {
    logic [15:0]          len;
    frame_pkg::udp_dest_t dest;
    logic                 macbit;
    // request raised while the previous frame is still active
    logic                 b2b;
  } tb_case_t;

  logic                 tx_clock;
  logic                 rst_n;
  logic                 udp_tx_request;
  logic [15:0]          udp_tx_length;
  frame_pkg::udp_dest_t udp_dest;
  logic [7:0]           udp_tx_data;
  logic                 macbit;
  logic                 udp_tx_enable;
  logic                 udp_tx_active;
  logic                 udp_data_strobe;
  logic [47:0]          local_mac;
  logic [3:0]           PHY_TX;
  logic                 PHY_TX_EN;

  tb_case_t    cases [n_cases];
  logic [7:0]  payload [max_payload];
  logic [7:0]  exp_q [$];
  logic [3:0]  nib_q [$];
  logic [31:0] lcg_state;
  int          strobe_cnt;
  int          enable_cnt;
  int          idle_run;
  int          frames_seen;
  logic        en_prev;
  logic        act_q;
  logic        act_prev;

  network_tx uut (
    .tx_clock        (tx_clock),
    .rst_n           (rst_n),
    .udp_tx_request  (udp_tx_request),
    .udp_tx_length   (udp_tx_length),
    .udp_dest        (udp_dest),
    .udp_tx_data     (udp_tx_data),
    .macbit          (macbit),
    .udp_tx_enable   (udp_tx_enable),
    .udp_tx_active   (udp_tx_active),
    .udp_data_strobe (udp_data_strobe),
    .local_mac       (local_mac),
    .PHY_TX          (PHY_TX),
    .PHY_TX_EN       (PHY_TX_EN)
  );

  // 8 ns period
  always #4 tx_clock = ~tx_clock;

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [47:0] got,
                             input logic [47:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic add_case(input int idx, input logic [15:0] len, input logic [47:0] mac,
                          input logic [31:0] ip, input logic [15:0] port,
                          input logic mb, input logic b2b);
    cases[idx].len       = len;
    cases[idx].dest.mac  = mac;
    cases[idx].dest.ip   = ip;
    cases[idx].dest.port = port;
    cases[idx].macbit    = mb;
    cases[idx].b2b       = b2b;
  endtask

  // one clock: drive payload, count strobes, collect nibbles
  task automatic tick();
    @(negedge tx_clock);
    // byte stays until the cycle after its strobe
    if (strobe_cnt < max_payload) begin
      udp_tx_data = payload[strobe_cnt];
    end
    if (udp_data_strobe) begin
      strobe_cnt++;
    end
    if (udp_tx_enable) begin
      enable_cnt++;
    end
    act_prev = act_q;
    act_q    = udp_tx_active;
    if (PHY_TX_EN) begin
      if (!en_prev && frames_seen > 0 && idle_run < min_gap_cycles) begin
        $display("PHY_TX_EN was low for only %0d cycles between frames", idle_run);
        abort_run();
      end
      if (!en_prev) begin
        frames_seen++;
      end
      nib_q.push_back(PHY_TX);
      idle_run = 0;
    end else begin
      idle_run++;
    end
    en_prev = PHY_TX_EN;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (udp_tx_active && t < 200) begin
      tick();
      t++;
    end
    if (udp_tx_active) begin
      $display("timed out waiting for udp_tx_active to fall");
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------------
  // reference frame, built from the protocol rules
  // ------------------------------------------------------------------------
  task automatic build_expected(input tb_case_t c, input logic [15:0] id);
    logic [7:0]  body [$];
    logic [15:0] w [14];
    logic [31:0] sum;
    logic [31:0] crc;
    logic [47:0] src;
    int          k;
    // ipv4 header words, checksum slot zero for the sum
    w[0] = 16'h4500;
    w[1] = 16'(net_cfg_pkg::ip_header_len + net_cfg_pkg::udp_header_len) + c.len;
    w[2] = id;
    w[3] = net_cfg_pkg::ip_flags_frag;
    w[4] = {net_cfg_pkg::ip_ttl, net_cfg_pkg::ip_proto_udp};
    w[5] = 16'h0000;
    w[6] = net_cfg_pkg::local_ip[31:16];
    w[7] = net_cfg_pkg::local_ip[15:0];
    w[8] = c.dest.ip[31:16];
    w[9] = c.dest.ip[15:0];
    sum = 32'd0;
    for (k = 0; k < 10; k++) begin
      sum = sum + 32'(w[k]);
    end
    sum  = (sum & 32'h0000_ffff) + (sum >> 16);
    sum  = (sum & 32'h0000_ffff) + (sum >> 16);
    w[5] = ~sum[15:0];
    // udp header, checksum left at zero
    w[10] = net_cfg_pkg::local_udp_port;
    w[11] = c.dest.port;
    w[12] = 16'(net_cfg_pkg::udp_header_len) + c.len;
    w[13] = 16'h0000;
    for (k = 0; k < 14; k++) begin
      body.push_back(w[k][15:8]);
      body.push_back(w[k][7:0]);
    end
    for (k = 0; k < int'(c.len); k++) begin
      body.push_back(payload[k]);
    end
    while (body.size() < net_cfg_pkg::min_ip_bytes) begin
      body.push_back(8'h00);
    end
    src    = net_cfg_pkg::local_mac_base;
    src[1] = ~c.macbit;
    exp_q.delete();
    repeat (net_cfg_pkg::preamble_len) exp_q.push_back(net_cfg_pkg::preamble_byte);
    exp_q.push_back(net_cfg_pkg::sfd_byte);
    for (k = 5; k >= 0; k--) begin
      exp_q.push_back(c.dest.mac[k*8 +: 8]);
    end
    for (k = 5; k >= 0; k--) begin
      exp_q.push_back(src[k*8 +: 8]);
    end
    exp_q.push_back(net_cfg_pkg::ethertype_ipv4[15:8]);
    exp_q.push_back(net_cfg_pkg::ethertype_ipv4[7:0]);
    foreach (body[k]) begin
      exp_q.push_back(body[k]);
    end
    // crc-32 from the first header byte, whole byte folded in at once
    crc = net_cfg_pkg::crc_residue_init;
    for (k = net_cfg_pkg::preamble_len + 1; k < exp_q.size(); k++) begin
      crc = crc ^ 32'(exp_q[k]);
      repeat (8) crc = crc[0] ? ((crc >> 1) ^ net_cfg_pkg::crc_poly) : (crc >> 1);
    end
    crc = ~crc;
    for (k = 0; k < 4; k++) begin
      exp_q.push_back(crc[k*8 +: 8]);
    end
  endtask

  // ------------------------------------------------------------------------
  // stimulus and checks
  // ------------------------------------------------------------------------
  initial begin
    tb_case_t    c;
    logic [47:0] exp_mac;
    logic [7:0]  got;
    logic        started;
    int          t;
    int          i;
    int          k;
    tx_clock       = 1'b0;
    rst_n          = 1'b0;
    udp_tx_request = 1'b0;
    udp_tx_length  = 16'd0;
    udp_dest       = '0;
    udp_tx_data    = 8'h00;
    macbit         = 1'b0;
    lcg_state      = lcg_seed;
    strobe_cnt     = 0;
    enable_cnt     = 0;
    idle_run       = 0;
    frames_seen    = 0;
    en_prev        = 1'b0;
    act_q          = 1'b0;
    act_prev       = 1'b0;
    for (k = 0; k < max_payload; k++) begin
      payload[k] = 8'h00;
    end
    // short, padded, exactly minimum, medium, largest
    add_case(0, 16'd1,    48'h00_1b_21_3a_4c_5d, 32'hc0a8_010a, 16'd5000,  1'b0, 1'b0);
    add_case(1, 16'd17,   48'h00_1b_21_3a_4c_5d, 32'hc0a8_010a, 16'd5001,  1'b1, 1'b1);
    add_case(2, 16'd18,   48'hf0_0d_ba_be_00_07, 32'h0a00_0001, 16'd53,    1'b1, 1'b0);
    add_case(3, 16'd100,  48'hf0_0d_ba_be_00_07, 32'h0a00_0001, 16'd8080,  1'b0, 1'b1);
    add_case(4, 16'd1472, 48'h00_e0_4c_68_11_22, 32'hac10_fffe, 16'd65535, 1'b0, 1'b0);
    repeat (4) @(negedge tx_clock);
    rst_n = 1'b1;

    // nothing moves without a request
    repeat (20) begin
      tick();
      check_value("udp_tx_enable", 48'(udp_tx_enable), 48'd0);
      check_value("udp_tx_active", 48'(udp_tx_active), 48'd0);
      check_value("udp_data_strobe", 48'(udp_data_strobe), 48'd0);
      check_value("PHY_TX_EN", 48'(PHY_TX_EN), 48'd0);
    end

    for (i = 0; i < n_cases; i++) begin
      c = cases[i];
      if (c.b2b) begin
        // previous frame still in its gap
        check_value("udp_tx_active", 48'(udp_tx_active), 48'd1);
      end else begin
        wait_idle();
      end
      for (k = 0; k < int'(c.len); k++) begin
        lcg_state  = lcg_next(lcg_state);
        payload[k] = lcg_state[23:16];
      end
      strobe_cnt = 0;
      enable_cnt = 0;
      nib_q.delete();
      udp_tx_request = 1'b1;
      udp_tx_length  = c.len;
      udp_dest       = c.dest;
      macbit         = c.macbit;

      t = 0;
      do begin
        tick();
        t++;
      end while (!udp_tx_enable && t < 100);
      if (!udp_tx_enable) begin
        $display("timed out waiting for udp_tx_enable in case %0d", i);
        abort_run();
      end
      // accepted only once the path went idle
      check_value("udp_tx_active", 48'(act_prev), 48'd0);
      udp_tx_request = 1'b0;
      // job must already hold its own copy
      udp_dest      = '1;
      udp_tx_length = 16'hffff;
      exp_mac    = net_cfg_pkg::local_mac_base;
      exp_mac[1] = ~c.macbit;
      check_value("local_mac", local_mac, exp_mac);
      build_expected(c, 16'(i));

      started = 1'b0;
      t = 0;
      do begin
        tick();
        t++;
        if (PHY_TX_EN) begin
          started = 1'b1;
        end
      end while (!(started && !PHY_TX_EN) && t < 4000);
      if (!started || PHY_TX_EN) begin
        $display("timed out waiting for the end of frame %0d on PHY_TX_EN", i);
        abort_run();
      end

      check_value("udp_data_strobe count", 48'(strobe_cnt), 48'(c.len));
      check_value("udp_tx_enable pulse count", 48'(enable_cnt), 48'd1);
      check_value("PHY_TX nibble count", 48'(nib_q.size()), 48'(2 * exp_q.size()));
      // low nibble first
      for (k = 0; k < exp_q.size(); k++) begin
        got = {nib_q[2*k+1], nib_q[2*k]};
        check_value($sformatf("PHY_TX byte %0d", k), 48'(got), 48'(exp_q[k]));
      end
    end

    wait_idle();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== network_tx.f ====
hw/net_cfg_pkg.sv
hw/frame_pkg.sv
hw/udp_tx_frontend.sv
hw/ip_udp_builder.sv
hw/mac_framer.sv
hw/nibble_tx.sv
hw/network_tx.sv
verification/network_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the udp transmit testbench with Verilator and run it
# exit status is nonzero unless the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module network_tx_tb -f network_tx.f -o network_tx_sim \
  && ./obj_dir/network_tx_sim | tee /dev/stderr | grep -F -q "Simulation finished: PASS" \
  || { echo "run_sim: simulation failed"; exit 1; }

echo "run_sim: simulation passed"
